// File: dual_piso_cfg_pkg.sv
`default_nettype none

// sizes of the two-lane serializer
// every derived count follows from the widths and depths set here
package dual_piso_cfg_pkg;

    // one input word per din_valid strobe
    localparam int word_width = 64;

    // one output beat per valid/ready transfer
    localparam int beat_width = 16;

    // beats cut from a single word, slice 0 leaves first
    localparam int beats_per_word = word_width / beat_width;

    // words held by the FIFO of one lane
    localparam int fifo_depth = 8;
    localparam int fifo_addr_width = $clog2(fifo_depth);

    // counter that walks the slices of a word
    localparam int beat_idx_width = $clog2(beats_per_word);

    // lanes feeding the merger and the width of the lane tag
    localparam int num_lanes = 2;
    localparam int lane_idx_width = $clog2(num_lanes);

endpackage

`default_nettype wire

// File: dual_piso_types_pkg.sv
`default_nettype none

// bundles that cross module boundaries in the serializer
package dual_piso_types_pkg;

    import dual_piso_cfg_pkg::*;

    // word offered to a lane on a plain strobe, there is no ready
    typedef struct packed {
        logic [word_width-1:0] data;
        logic                  valid;
    } word_in_t;

    // beat data between a lane and the merger
    // valid and ready run beside it as separate wires
    typedef struct packed {
        logic [beat_width-1:0] data;
    } lane_beat_t;

    // beat on the merged output stream
    // lane tells where it came from, last closes the word
    typedef struct packed {
        logic [beat_width-1:0]     data;
        logic [lane_idx_width-1:0] lane;
        logic                      last;
    } merged_beat_t;

endpackage

`default_nettype wire

// File: bram_infer.sv
`timescale 1ns/1ps
`default_nettype none

// simple dual-port RAM, one write port and one read port
// the read output is registered so synthesis maps it onto block RAM
module bram_infer #(
    parameter int n_addr     = 8,
    parameter int data_width = 64
) (
    input  logic                      clk,
    input  logic                      wen,
    input  logic                      ren,
    input  logic [$clog2(n_addr)-1:0] wadd,
    input  logic [$clog2(n_addr)-1:0] radd,
    input  logic [data_width-1:0]     win,
    output logic [data_width-1:0]     wout
);

    logic [data_width-1:0] mem [n_addr];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[wadd] <= win;
        end
    end

    // the output word stays put until the next read, so a lane can
    // keep slicing it for as long as it needs
    always_ff @(posedge clk) begin
        if (ren) begin
            wout <= mem[radd];
        end
    end

endmodule

`default_nettype wire

// File: skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// two-entry register slice on a valid/ready stream
// din_ready comes straight from a flop, so the ready path from the
// consumer ends here and does not reach the producer
module skid_buffer (
    input  logic                            clk,
    input  logic                            rst,
    input  dual_piso_types_pkg::lane_beat_t din,
    input  logic                            din_valid,
    output logic                            din_ready,
    output dual_piso_types_pkg::lane_beat_t dout,
    output logic                            dout_valid,
    input  logic                            dout_ready
);

    import dual_piso_types_pkg::*;

    lane_beat_t skid_beat;
    logic       skid_valid;
    logic       main_free;

    // the main register can load when it is empty or draining this cycle
    assign main_free = !dout_valid || dout_ready;

    // input ready drops only once both entries are taken
    assign din_ready = !skid_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            dout_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            // the skid entry is older than anything on din, it goes first
            dout_valid <= skid_valid || din_valid;
            skid_valid <= 1'b0;
        end else if (din_valid && din_ready) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            dout <= skid_valid ? skid_beat : din;
        end
        // this copy only matters when the main register is stalled
        if (din_ready) begin
            skid_beat <= din;
        end
    end

    // a beat on offer is never withdrawn or changed before it is taken
    assert property (@(posedge clk) disable iff (rst)
        dout_valid && !dout_ready |=> dout_valid && $stable(dout));

endmodule

`default_nettype wire

// File: piso.sv
`timescale 1ns/1ps
`default_nettype none

// one serializer lane
// word in -> FIFO on block RAM -> slice mux -> skid buffer -> beats out
module piso (
    input  logic                            clk,
    input  logic                            rst,
    input  dual_piso_types_pkg::word_in_t   word_in,
    output logic                            fifo_full,
    output dual_piso_types_pkg::lane_beat_t beat,
    output logic                            beat_valid,
    input  logic                            beat_ready
);

    import dual_piso_cfg_pkg::*;
    import dual_piso_types_pkg::*;

    typedef enum logic {
        st_idle,
        st_busy
    } state_t;

    // pointers carry one extra bit to tell full from empty
    logic [fifo_addr_width:0] wptr;
    logic [fifo_addr_width:0] rptr;
    logic [fifo_addr_width:0] fill;
    logic                     empty;
    logic                     full;
    logic                     ram_wen;
    logic                     ram_ren;
    logic [word_width-1:0]    rd_word;

    state_t                    state;
    logic [beat_idx_width-1:0] slice;
    logic                      last_slice;

    lane_beat_t sk_din;
    logic       sk_valid;
    logic       sk_ready;

    assign empty = (wptr == rptr);
    assign full  = (wptr[fifo_addr_width] != rptr[fifo_addr_width]) &&
                   (wptr[fifo_addr_width-1:0] == rptr[fifo_addr_width-1:0]);
    assign fill  = wptr - rptr;

    assign fifo_full = full;

    // a word offered while full is dropped and never reaches the RAM
    assign ram_wen = word_in.valid && !full;

    // pop a word only when the slicer is free and the skid buffer has room
    assign ram_ren = (state == st_idle) && !empty && sk_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wptr <= '0;
        end else if (ram_wen) begin
            wptr <= wptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rptr <= '0;
        end else if (ram_ren) begin
            rptr <= rptr + 1'b1;
        end
    end

    bram_infer #(
        .n_addr     (fifo_depth),
        .data_width (word_width)
    ) ram0 (
        .clk  (clk),
        .wen  (ram_wen),
        .ren  (ram_ren),
        .wadd (wptr[fifo_addr_width-1:0]),
        .radd (rptr[fifo_addr_width-1:0]),
        .win  (word_in.data),
        .wout (rd_word)
    );

    assign last_slice = (slice == beat_idx_width'(beats_per_word - 1));

    // the RAM output is valid from the first busy cycle on, so the slices
    // can be offered right away; the slice only advances on a transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            slice <= '0;
        end else begin
            case (state)
                st_idle: begin
                    slice <= '0;
                    if (ram_ren) begin
                        state <= st_busy;
                    end
                end
                st_busy: begin
                    if (sk_ready) begin
                        slice <= slice + 1'b1;
                        if (last_slice) begin
                            state <= st_idle;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign sk_valid    = (state == st_busy);
    assign sk_din.data = rd_word[slice * beat_width +: beat_width];

    skid_buffer skid0 (
        .clk        (clk),
        .rst        (rst),
        .din        (sk_din),
        .din_valid  (sk_valid),
        .din_ready  (sk_ready),
        .dout       (beat),
        .dout_valid (beat_valid),
        .dout_ready (beat_ready)
    );

    // a write must land in a slot that holds no unread word
    assert property (@(posedge clk) disable iff (rst)
        ram_wen |-> fill < (fifo_addr_width + 1)'(fifo_depth));

    // the pointers never drift further apart than the RAM holds
    assert property (@(posedge clk) disable iff (rst)
        fill <= (fifo_addr_width + 1)'(fifo_depth));

endmodule

`default_nettype wire

// File: lane_merge.sv
`timescale 1ns/1ps
`default_nettype none

// merges the beat streams of two lanes into one output stream
// a lane keeps the grant for a whole word and lanes alternate at word ends
module lane_merge (
    input  logic                              clk,
    input  logic                              rst,
    input  dual_piso_types_pkg::lane_beat_t   beat_a,
    input  logic                              beat_valid_a,
    output logic                              beat_ready_a,
    input  dual_piso_types_pkg::lane_beat_t   beat_b,
    input  logic                              beat_valid_b,
    output logic                              beat_ready_b,
    output dual_piso_types_pkg::merged_beat_t out_beat,
    output logic                              out_valid,
    input  logic                              out_ready
);

    import dual_piso_cfg_pkg::*;
    import dual_piso_types_pkg::*;

    logic [lane_idx_width-1:0] grant;
    logic [lane_idx_width-1:0] other;
    logic [beat_idx_width-1:0] beat_cnt;
    logic                      last_beat;
    logic                      can_load;
    logic                      sel_valid;
    logic                      other_valid;
    logic                      take;
    lane_beat_t                sel_beat;

    // round robin over the lanes, wrapping after the highest index
    assign other = (grant == lane_idx_width'(num_lanes - 1)) ? '0 : grant + 1'b1;

    assign sel_valid   = (grant == '0) ? beat_valid_a : beat_valid_b;
    assign other_valid = (grant == '0) ? beat_valid_b : beat_valid_a;
    assign sel_beat    = (grant == '0) ? beat_a : beat_b;

    // the output register takes a new beat when empty or being drained
    assign can_load = !out_valid || out_ready;
    assign take     = can_load && sel_valid;

    assign beat_ready_a = can_load && (grant == '0);
    assign beat_ready_b = can_load && (grant != '0);

    assign last_beat = (beat_cnt == beat_idx_width'(beats_per_word - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            grant     <= '0;
            beat_cnt  <= '0;
            out_valid <= 1'b0;
        end else begin
            if (can_load) begin
                out_valid <= sel_valid;
            end
            if (take) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat && other_valid) begin
                    grant <= other;
                end
            end else if (beat_cnt == '0 && !sel_valid && other_valid) begin
                // between words an idle granted lane hands over to a waiting
                // one, otherwise the waiting lane could starve
                grant <= other;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_beat.data <= sel_beat.data;
            out_beat.lane <= grant;
            out_beat.last <= last_beat;
        end
    end

    // beats of one word are never interleaved with the other lane
    assert property (@(posedge clk) disable iff (rst)
        beat_cnt != '0 |-> $stable(grant));

endmodule

`default_nettype wire

// File: dual_piso_top.sv
`timescale 1ns/1ps
`default_nettype none

// two serializer lanes feeding one merged beat stream
module dual_piso_top (
    input  logic                              clk,
    input  logic                              rst,
    input  dual_piso_types_pkg::word_in_t     word_in_a,
    input  dual_piso_types_pkg::word_in_t     word_in_b,
    output logic                              fifo_full_a,
    output logic                              fifo_full_b,
    output dual_piso_types_pkg::merged_beat_t out_beat,
    output logic                              out_valid,
    input  logic                              out_ready
);

    import dual_piso_types_pkg::*;

    lane_beat_t beat_a;
    lane_beat_t beat_b;
    logic       beat_valid_a;
    logic       beat_valid_b;
    logic       beat_ready_a;
    logic       beat_ready_b;

    piso lane_a (
        .clk        (clk),
        .rst        (rst),
        .word_in    (word_in_a),
        .fifo_full  (fifo_full_a),
        .beat       (beat_a),
        .beat_valid (beat_valid_a),
        .beat_ready (beat_ready_a)
    );

    piso lane_b (
        .clk        (clk),
        .rst        (rst),
        .word_in    (word_in_b),
        .fifo_full  (fifo_full_b),
        .beat       (beat_b),
        .beat_valid (beat_valid_b),
        .beat_ready (beat_ready_b)
    );

    // lane a carries tag 0 and lane b tag 1
    lane_merge merge0 (
        .clk          (clk),
        .rst          (rst),
        .beat_a       (beat_a),
        .beat_valid_a (beat_valid_a),
        .beat_ready_a (beat_ready_a),
        .beat_b       (beat_b),
        .beat_valid_b (beat_valid_b),
        .beat_ready_b (beat_ready_b),
        .out_beat     (out_beat),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

endmodule

`default_nettype wire

// File: tb_dual_piso.sv
`timescale 1ns/1ps
`default_nettype none

// random-stimulus testbench for dual_piso_top
// one queue per lane holds the accepted words and the monitor checks every beat
module tb_dual_piso;

    import dual_piso_cfg_pkg::*;
    import dual_piso_types_pkg::*;

    localparam int t1_words = 12;
    localparam int t2_words = 40;
    localparam int t3_words = 6;
    localparam int t4_words = 20;
    localparam int run_words = t1_words + 2 * t2_words + 2 * t3_words + t4_words;
    // twenty cycles for each beat of every offered word, plus reset and drain room
    localparam int limit_cycles = run_words * beats_per_word * 20 + 1000;

    logic         clk = 1'b0;
    logic         rst;
    word_in_t     word_in_a;
    word_in_t     word_in_b;
    logic         fifo_full_a;
    logic         fifo_full_b;
    merged_beat_t out_beat;
    logic         out_valid;
    logic         out_ready;

    logic [word_width-1:0]     q_a [$];
    logic [word_width-1:0]     q_b [$];
    logic [lane_idx_width-1:0] word_lanes [$];
    logic [lane_idx_width-1:0] cur_lane = '0;
    int   beat_idx = 0;
    int   accepted [num_lanes] = '{default: 0};
    int   dropped [num_lanes] = '{default: 0};
    int   out_beats [num_lanes] = '{default: 0};
    logic saw_full [num_lanes] = '{default: 1'b0};
    int   errors = 0;
    int   checks = 0;

    always #10 clk = ~clk;

    dual_piso_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .word_in_a   (word_in_a),
        .word_in_b   (word_in_b),
        .fifo_full_a (fifo_full_a),
        .fifo_full_b (fifo_full_b),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

    task automatic check_beat(input string name, input merged_beat_t got,
                              input merged_beat_t exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: got %h lane=%0d last=%0b, expected %h lane=%0d last=%0b",
                     $time, name, got.data, got.lane, got.last, exp.data, exp.lane, exp.last);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("[ERROR] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: got %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // a word counts as accepted when valid meets a low fifo_full at the edge
    task automatic watch_input(input int lane, input word_in_t w, input logic full);
        if (full) begin
            saw_full[lane] = 1'b1;
        end
        if (w.valid && full) begin
            dropped[lane]++;
        end else if (w.valid) begin
            accepted[lane]++;
            if (lane == 0) begin
                q_a.push_back(w.data);
            end else begin
                q_b.push_back(w.data);
            end
        end
    endtask

    task automatic take_beat(input merged_beat_t got);
        merged_beat_t          exp;
        logic [word_width-1:0] word;
        int                    pending;
        // the lane of a new word is the merger's choice, later beats must follow it
        exp.lane = (beat_idx == 0) ? got.lane : cur_lane;
        pending = (exp.lane == '0) ? q_a.size() : q_b.size();
        if (pending == 0) begin
            $display("t=%0t lane %0d sent a beat with no accepted word behind it",
                     $time, exp.lane);
            errors++;
            return;
        end
        word = (exp.lane == '0) ? q_a[0] : q_b[0];
        exp.data = word[beat_idx * beat_width +: beat_width];
        exp.last = (beat_idx == beats_per_word - 1);
        check_beat("out_beat", got, exp);
        if (beat_idx == 0) begin
            cur_lane = exp.lane;
            word_lanes.push_back(exp.lane);
        end
        out_beats[exp.lane]++;
        if (exp.last) begin
            if (exp.lane == '0) begin
                q_a.delete(0);
            end else begin
                q_b.delete(0);
            end
            beat_idx = 0;
        end else begin
            beat_idx++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            watch_input(0, word_in_a, fifo_full_a);
            watch_input(1, word_in_b, fifo_full_b);
            if (out_valid && out_ready) begin
                take_beat(out_beat);
            end
        end
    end

    task automatic offer_words(input int n_a, input int n_b, input int gap, input bit rand_ready);
        int left_a;
        int left_b;
        left_a = n_a;
        left_b = n_b;
        while (left_a > 0 || left_b > 0) begin
            @(posedge clk);
            if (left_a > 0 && $urandom_range(gap) == 0) begin
                word_in_a <= '{data: {$urandom, $urandom}, valid: 1'b1};
                left_a--;
            end else begin
                word_in_a <= '0;
            end
            if (left_b > 0 && $urandom_range(gap) == 0) begin
                word_in_b <= '{data: {$urandom, $urandom}, valid: 1'b1};
                left_b--;
            end else begin
                word_in_b <= '0;
            end
            if (rand_ready) begin
                out_ready <= ($urandom_range(1) == 1);
            end
        end
        @(posedge clk);
        word_in_a <= '0;
        word_in_b <= '0;
    endtask

    // opens the output and waits for every accepted word to leave
    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        out_ready <= 1'b1;
        do begin
            @(negedge clk);
            waited++;
        end while ((q_a.size() + q_b.size() != 0 || out_valid) && waited < 500);
        // a few more cycles so that a stray or repeated beat is still seen
        repeat (10) @(negedge clk);
        if (q_a.size() + q_b.size() != 0) begin
            $display("t=%0t %0d accepted words never left the serializer",
                     $time, q_a.size() + q_b.size());
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int start_err);
        $display("test %0d %s: %0d errors", num, name, errors - start_err);
    endtask

    initial begin
        int start_err;
        void'($urandom(75));
        rst = 1'b1;
        word_in_a = '0;
        word_in_b = '0;
        out_ready = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        start_err = errors;
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("fifo_full_a", fifo_full_a, 1'b0);
        check_flag("fifo_full_b", fifo_full_b, 1'b0);
        report_test(6, "reset state", start_err);

        start_err = errors;
        @(posedge clk);
        out_ready <= 1'b1;
        offer_words(t1_words, 0, 3, 1'b0);
        drain();
        report_test(1, "single lane", start_err);

        start_err = errors;
        offer_words(t2_words, t2_words, 2, 1'b1);
        drain();
        report_test(2, "both lanes random", start_err);

        // both lanes are loaded behind a stalled output before it opens
        start_err = errors;
        word_lanes.delete();
        @(posedge clk);
        out_ready <= 1'b0;
        offer_words(t3_words, t3_words, 0, 1'b0);
        repeat (20) @(posedge clk);
        drain();
        check_count("words in fairness run", word_lanes.size(), 2 * t3_words);
        for (int i = 1; i < word_lanes.size(); i++) begin
            if (word_lanes[i] == word_lanes[i-1]) begin
                $display("lane %0d sent words %0d and %0d in a row while both were loaded",
                         word_lanes[i], i - 1, i);
                errors++;
            end
        end
        report_test(3, "fairness", start_err);

        start_err = errors;
        saw_full[0] = 1'b0;
        saw_full[1] = 1'b0;
        dropped[0] = 0;
        @(posedge clk);
        out_ready <= 1'b0;
        offer_words(t4_words, 0, 0, 1'b0);
        check_flag("fifo_full_a", saw_full[0], 1'b1);
        check_flag("fifo_full_b", saw_full[1], 1'b0);
        if (dropped[0] == 0) begin
            $display("no word was dropped although %0d went into a stalled lane", t4_words);
            errors++;
        end
        drain();
        report_test(4, "overflow", start_err);

        start_err = errors;
        check_count("beats of lane a", out_beats[0], beats_per_word * accepted[0]);
        check_count("beats of lane b", out_beats[1], beats_per_word * accepted[1]);
        check_count("words left in queue a", q_a.size(), 0);
        check_count("words left in queue b", q_b.size(), 0);
        report_test(5, "totals", start_err);

        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(limit_cycles * 20);
        $display("watchdog ran out after %0d cycles, the run never finished", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: dual_piso.f
dual_piso_cfg_pkg.sv
dual_piso_types_pkg.sv
bram_infer.sv
skid_buffer.sv
piso.sv
lane_merge.sv
dual_piso_top.sv
tb_dual_piso.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the dual_piso testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dual_piso \
    -f dual_piso.f -o sim_dual_piso > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_dual_piso > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation ended with an error status, see sim.log"
    exit 1
fi

grep -qx "TEST OK" sim.log
if [ $? -eq 0 ]; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see sim.log"
exit 1
